// File: common/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// Load buffer depth in entries.
`define LB_ENTRIES 16

// Sequence numbers wrap, so age is taken from the signed difference.
`define SQN_W 6

`define ADDR_W 32

// APB register window, byte addressed.
`define APB_AW 4

`endif

// File: common/lsqPkg.sv
`default_nettype none
`include "lsq_macros.svh"

package lsqPkg;

    typedef logic [`SQN_W-1:0] SqN;

    typedef struct packed {
        logic              valid;
        SqN                sqN;     // Instruction sequence number.
        SqN                loadSqN; // Slot in load order.
        logic [`ADDR_W-1:0] addr;
    } LoadOp;

    typedef struct packed {
        logic              valid;
        SqN                sqN;
        SqN                loadSqN;
        SqN                storeSqN;
        logic [`ADDR_W-1:0] addr;
        logic [31:0]       pc;
        logic              compressed; // Set for a 16-bit encoding.
    } StoreOp;

    // Redirect toward the front end, used both ways.
    typedef struct packed {
        logic        taken;
        logic        flush;
        SqN          sqN;
        SqN          loadSqN;
        SqN          storeSqN;
        logic [31:0] dstPC;
    } BranchProv;

    typedef struct packed {
        logic               valid;
        SqN                 sqN;
        logic [`ADDR_W-3:0] addr; // Word address.
    } LBEntry;

    typedef enum logic [`APB_AW-1:0] {
        CTRL    = 4'h0,
        VIOLCNT = 4'h4,
        LASTPC  = 4'h8,
        STATUS  = 4'hC
    } lsqRegAddr;

endpackage

`default_nettype wire

// File: hw/loadBuffer/storeOrderCheck.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module storeOrderCheck (
    input  lsqPkg::LBEntry entries[`LB_ENTRIES],
    input  lsqPkg::LoadOp  loadUop,
    input  logic           loadStall,
    input  lsqPkg::StoreOp storeUop,
    output logic           hit
);

    logic [`ADDR_W-3:0]     storeWord;
    logic [`LB_ENTRIES-1:0] entryHit;
    logic                   sameCycleHit;

    assign storeWord = storeUop.addr[`ADDR_W-1:2];

    //////////////////////////////////////////////////
    // Search of the held loads
    //////////////////////////////////////////////////

    // An entry is a hit when it holds the store's word and is not older than the store.
    always_comb begin
        for (int i = 0; i < `LB_ENTRIES; i++) begin
            entryHit[i] = entries[i].valid
                && (entries[i].addr == storeWord)
                && ($signed(storeUop.sqN - entries[i].sqN) <= 0);
        end
    end

    //////////////////////////////////////////////////
    // Load executing in the same cycle
    //////////////////////////////////////////////////

    // This load is not in the array yet but has already read its data.
    always_comb begin
        sameCycleHit = loadUop.valid && !loadStall
            && (loadUop.addr[`ADDR_W-1:2] == storeWord)
            && ($signed(storeUop.sqN - loadUop.sqN) <= 0);
    end

    assign hit = (|entryHit) || sameCycleHit;

endmodule

`default_nettype wire

// File: hw/loadBuffer/loadBuffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module loadBuffer (
    input  logic              clk,
    input  logic              rst,
    input  lsqPkg::SqN        commitSqN,
    input  logic              loadStall,
    input  logic              storeStall,
    input  lsqPkg::LoadOp     loadUop,
    input  lsqPkg::StoreOp    storeUop,
    input  lsqPkg::BranchProv branchIn,
    input  logic              checkEnable,
    output lsqPkg::BranchProv branchOut,
    output lsqPkg::SqN        maxLoadSqN,
    output logic              violationPulse,
    output logic [31:0]       violationPc,
    output logic [4:0]        occupancy
);
    import lsqPkg::*;

    localparam int IDX_W = $clog2(`LB_ENTRIES);

    LBEntry entries[`LB_ENTRIES];

    SqN baseIndex;
    SqN baseNext;

    logic             commitShift;
    logic             loadAccept;
    logic             storeAccept;
    logic             storeHit;
    logic [IDX_W-1:0] loadIdx;
    logic [4:0]       validCount;

    //////////////////////////////////////////////////
    // Acceptance and base index
    //////////////////////////////////////////////////

    // Only the head may retire, and never while a branch is resolving.
    assign commitShift = !branchIn.taken && entries[0].valid
        && ($signed(commitSqN - entries[0].sqN) > 0);

    assign loadAccept = loadUop.valid && !loadStall
        && (!branchIn.taken || $signed(loadUop.sqN - branchIn.sqN) <= 0);
    assign storeAccept = storeUop.valid && !storeStall
        && (!branchIn.taken || $signed(storeUop.sqN - branchIn.sqN) <= 0);

    always_comb begin
        baseNext = baseIndex;
        if (branchIn.taken) begin
            if (branchIn.flush)
                baseNext = branchIn.loadSqN;
        end else if (commitShift) begin
            baseNext = baseIndex + SqN'(1);
        end
    end

    // Slot is taken against the base after this cycle's shift.
    assign loadIdx = loadUop.loadSqN[IDX_W-1:0] - baseNext[IDX_W-1:0];

    //////////////////////////////////////////////////
    // Entry array
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `LB_ENTRIES; i++)
                entries[i].valid <= 1'b0;
        end else begin
            if (branchIn.taken) begin
                for (int i = 0; i < `LB_ENTRIES; i++) begin
                    if ($signed(entries[i].sqN - branchIn.sqN) > 0)
                        entries[i].valid <= 1'b0; // Younger than the branch.
                end
            end else if (commitShift) begin
                for (int i = 0; i < `LB_ENTRIES - 1; i++)
                    entries[i] <= entries[i+1];
                entries[`LB_ENTRIES-1].valid <= 1'b0;
            end

            // Later assignment wins over the shift for the same slot.
            if (loadAccept) begin
                entries[loadIdx].valid <= 1'b1;
                entries[loadIdx].sqN   <= loadUop.sqN;
                entries[loadIdx].addr  <= loadUop.addr[`ADDR_W-1:2];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex  <= '0;
            maxLoadSqN <= SqN'(`LB_ENTRIES - 1);
        end else begin
            baseIndex  <= baseNext;
            maxLoadSqN <= baseIndex + SqN'(`LB_ENTRIES - 1); // Lags the base by a cycle.
        end
    end

    //////////////////////////////////////////////////
    // Order violation redirect
    //////////////////////////////////////////////////

    storeOrderCheck u_check (
        .entries  (entries),
        .loadUop  (loadUop),
        .loadStall(loadStall),
        .storeUop (storeUop),
        .hit      (storeHit)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            branchOut.taken <= 1'b0;
        end else begin
            branchOut.taken <= storeAccept && storeHit && checkEnable;
            if (storeAccept) begin
                // Restart right after the store so the load reads again.
                branchOut.flush    <= 1'b0;
                branchOut.sqN      <= storeUop.sqN;
                branchOut.loadSqN  <= storeUop.loadSqN;
                branchOut.storeSqN <= storeUop.storeSqN;
                branchOut.dstPC    <= storeUop.pc + (storeUop.compressed ? 32'd2 : 32'd4);
            end
        end
    end

    assign violationPulse = branchOut.taken;
    assign violationPc    = branchOut.dstPC;

    always_comb begin
        validCount = '0;
        for (int i = 0; i < `LB_ENTRIES; i++)
            validCount = validCount + 5'(entries[i].valid);
    end

    always_ff @(posedge clk) begin
        if (rst)
            occupancy <= '0;
        else
            occupancy <= validCount;
    end

endmodule

`default_nettype wire

// File: hw/lsqConfig.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module lsqConfig (
    input  logic               clk,
    input  logic               rst,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               checkEnable,
    input  logic               violationPulse,
    input  logic [31:0]        violationPc,
    input  logic [4:0]         occupancy
);
    import lsqPkg::*;

    logic        writeEn;
    logic        readEn;
    logic [15:0] violCnt;
    logic [31:0] lastPc;

    // No wait states and no error responses.
    assign pready  = psel;
    assign pslverr = 1'b0;

    assign writeEn = psel && penable && pwrite;
    assign readEn  = psel && penable && !pwrite;

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            checkEnable <= 1'b1;
            violCnt     <= '0;
            lastPc      <= '0;
        end else begin
            if (writeEn && paddr == CTRL)
                checkEnable <= pwdata[0];

            // A write of any value clears the count.
            if (writeEn && paddr == VIOLCNT)
                violCnt <= '0;
            else if (violationPulse && violCnt != 16'hffff)
                violCnt <= violCnt + 16'd1;

            if (violationPulse)
                lastPc <= violationPc;
        end
    end

    //////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////

    always_comb begin
        prdata = '0;
        if (readEn) begin
            case (paddr)
                CTRL:    prdata = {31'd0, checkEnable};
                VIOLCNT: prdata = {16'd0, violCnt};
                LASTPC:  prdata = lastPc;
                STATUS:  prdata = {27'd0, occupancy};
                default: prdata = '0; // Unmapped.
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/memOrderTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module memOrderTop (
    input  logic               clk,
    input  logic               rst,
    input  lsqPkg::LoadOp      loadUop,
    input  lsqPkg::StoreOp     storeUop,
    input  logic               loadStall,
    input  logic               storeStall,
    input  lsqPkg::SqN         commitSqN,
    input  lsqPkg::BranchProv  branchIn,
    output lsqPkg::BranchProv  branchOut,
    output lsqPkg::SqN         maxLoadSqN,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [`APB_AW-1:0] paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    logic        checkEnable;
    logic        violationPulse;
    logic [31:0] violationPc;
    logic [4:0]  occupancy;

    loadBuffer u_loadBuffer (
        .clk           (clk),
        .rst           (rst),
        .commitSqN     (commitSqN),
        .loadStall     (loadStall),
        .storeStall    (storeStall),
        .loadUop       (loadUop),
        .storeUop      (storeUop),
        .branchIn      (branchIn),
        .checkEnable   (checkEnable),
        .branchOut     (branchOut),
        .maxLoadSqN    (maxLoadSqN),
        .violationPulse(violationPulse),
        .violationPc   (violationPc),
        .occupancy     (occupancy)
    );

    lsqConfig u_config (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .checkEnable   (checkEnable),
        .violationPulse(violationPulse),
        .violationPc   (violationPc),
        .occupancy     (occupancy)
    );

endmodule

`default_nettype wire

// File: verif/lsqRefModel.svh
`ifndef LSQ_REF_MODEL_SVH
`define LSQ_REF_MODEL_SVH

// Shadow of the load buffer, indexed directly by load sequence number.
logic        mValid[2**`SQN_W];
SqN          mSqN[2**`SQN_W];
logic [29:0] mWord[2**`SQN_W];
SqN          mBase;
SqN          expMax;
logic [4:0]  expOcc;
BranchProv   expBranch;
logic        mEnable;
logic [15:0] mViolCnt;
logic [31:0] mLastPc;
logic [31:0] lfsr;

function automatic logic [31:0] lfsrStep(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// One LFSR step per bit taken.
function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsr[0]};
        lfsr = lfsrStep(lfsr);
    end
    return r;
endfunction

// True when a is younger than b in the wrapping sequence space.
function automatic logic isYounger(SqN a, SqN b);
    SqN d;
    d = a - b;
    return (d != '0) && !d[`SQN_W-1];
endfunction

function automatic logic refHit(StoreOp st, LoadOp ld, logic ldStall);
    logic h;
    h = 1'b0;
    for (int i = 0; i < 2**`SQN_W; i++) begin
        if (mValid[i] && mWord[i] == st.addr[31:2] && !isYounger(st.sqN, mSqN[i]))
            h = 1'b1;
    end
    if (ld.valid && !ldStall && ld.addr[31:2] == st.addr[31:2] && !isYounger(st.sqN, ld.sqN))
        h = 1'b1; // The load read memory before the store wrote it.
    return h;
endfunction

function automatic BranchProv refRedirect(StoreOp st);
    BranchProv b;
    b.taken    = 1'b1;
    b.flush    = 1'b0;
    b.sqN      = st.sqN;
    b.loadSqN  = st.loadSqN;
    b.storeSqN = st.storeSqN;
    b.dstPC    = st.pc + (st.compressed ? 32'd2 : 32'd4);
    return b;
endfunction

function automatic logic [31:0] regRead(logic [`APB_AW-1:0] a);
    case (a)
        CTRL:    return {31'd0, mEnable};
        VIOLCNT: return {16'd0, mViolCnt};
        LASTPC:  return mLastPc;
        STATUS:  return {27'd0, expOcc};
        default: return 32'd0;
    endcase
endfunction

task automatic modelReset();
    for (int i = 0; i < 2**`SQN_W; i++)
        mValid[i] = 1'b0;
    mBase     = '0;
    expMax    = SqN'(15);
    expOcc    = '0;
    expBranch = '0;
    mEnable   = 1'b1;
    mViolCnt  = '0;
    mLastPc   = '0;
endtask

// Advances the model by one clock edge from the inputs seen at that edge.
task automatic modelStep();
    logic      commitNow;
    logic      ldAcc;
    logic      stAcc;
    logic      wr;
    BranchProv prev;
    BranchProv nb;
    int        cnt;
    prev      = expBranch;
    wr        = psel && penable && pwrite;
    commitNow = !branchIn.taken && mValid[mBase] && isYounger(commitSqN, mSqN[mBase]);
    ldAcc = loadUop.valid && !loadStall
        && !(branchIn.taken && isYounger(loadUop.sqN, branchIn.sqN));
    stAcc = storeUop.valid && !storeStall
        && !(branchIn.taken && isYounger(storeUop.sqN, branchIn.sqN));

    if (stAcc) begin
        nb       = refRedirect(storeUop);
        nb.taken = refHit(storeUop, loadUop, loadStall) && mEnable;
        expBranch = nb;
    end else begin
        expBranch.taken = 1'b0;
    end

    if (wr && paddr == VIOLCNT)
        mViolCnt = '0;
    else if (prev.taken && mViolCnt != 16'hffff)
        mViolCnt = mViolCnt + 16'd1;
    if (prev.taken)
        mLastPc = prev.dstPC;
    if (wr && paddr == CTRL)
        mEnable = pwdata[0];

    cnt = 0;
    for (int i = 0; i < 2**`SQN_W; i++)
        cnt += int'(mValid[i]);
    expOcc = 5'(cnt);
    expMax = mBase + SqN'(15);

    if (branchIn.taken) begin
        for (int i = 0; i < 2**`SQN_W; i++) begin
            if (mValid[i] && isYounger(mSqN[i], branchIn.sqN))
                mValid[i] = 1'b0;
        end
        if (branchIn.flush)
            mBase = branchIn.loadSqN;
    end else if (commitNow) begin
        mValid[mBase] = 1'b0;
        mBase = mBase + SqN'(1);
    end
    if (ldAcc) begin
        mValid[loadUop.loadSqN] = 1'b1;
        mSqN[loadUop.loadSqN]   = loadUop.sqN;
        mWord[loadUop.loadSqN]  = loadUop.addr[31:2];
    end
endtask

`endif

// File: verif/memOrderTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module memOrderTb;
    import lsqPkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 120;

    logic               clk;
    logic               rst;
    LoadOp              loadUop;
    StoreOp             storeUop;
    logic               loadStall;
    logic               storeStall;
    SqN                 commitSqN;
    BranchProv          branchIn;
    BranchProv          branchOut;
    SqN                 maxLoadSqN;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;
    SqN                 nextLq;
    SqN                 storeCnt;

    `include "lsqRefModel.svh"

    memOrderTop u_dut (
        .clk       (clk),
        .rst       (rst),
        .loadUop   (loadUop),
        .storeUop  (storeUop),
        .loadStall (loadStall),
        .storeStall(storeStall),
        .commitSqN (commitSqN),
        .branchIn  (branchIn),
        .branchOut (branchOut),
        .maxLoadSqN(maxLoadSqN),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic failRun();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkBranch(string name, BranchProv exp, BranchProv act);
        if (act.taken !== exp.taken || (exp.taken && act !== exp)) begin
            $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkSqN(string name, SqN exp, SqN act);
        if (act !== exp) begin
            $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
            failRun();
        end
    endtask

    task automatic checkWord(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected 0x%h actual 0x%h", name, exp, act);
            failRun();
        end
    endtask

    // Outputs are read before this edge's register updates land.
    always @(posedge clk) begin
        if (rst) begin
            modelReset();
        end else begin
            checkBranch("branchOut", expBranch, branchOut);
            checkSqN("maxLoadSqN", expMax, maxLoadSqN);
            checkWord("pready", {31'd0, psel}, {31'd0, pready});
            checkWord("pslverr", 32'd0, {31'd0, pslverr});
            if (psel && penable && !pwrite)
                checkWord("prdata", regRead(paddr), prdata);
            modelStep();
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + 10 * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in time.");
        failRun();
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic nextCycle();
        @(negedge clk);
        loadUop.valid  = 1'b0;
        storeUop.valid = 1'b0;
        branchIn.taken = 1'b0;
        loadStall      = 1'b0;
        storeStall     = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
    endtask

    task automatic driveLoad(SqN sq, logic [29:0] word, logic stall);
        loadUop.valid   = 1'b1;
        loadUop.sqN     = sq;
        loadUop.loadSqN = nextLq;
        loadUop.addr    = {word, 2'b00};
        loadStall       = stall;
        if (!stall)
            nextLq = nextLq + SqN'(1);
    endtask

    task automatic driveStore(SqN sq, logic [29:0] word, logic comp);
        logic [31:0] newPc;
        newPc = randBits(31) << 1;
        storeUop.valid      = 1'b1;
        storeUop.sqN        = sq;
        storeUop.loadSqN    = nextLq;
        storeUop.storeSqN   = storeCnt;
        storeUop.addr       = {word, 2'b00};
        storeUop.pc         = newPc;
        storeUop.compressed = comp;
        storeCnt = storeCnt + SqN'(1);
    endtask

    task automatic driveBranch(SqN sq, SqN lq, logic flush);
        branchIn.taken   = 1'b1;
        branchIn.flush   = flush;
        branchIn.sqN     = sq;
        branchIn.loadSqN = lq;
    endtask

    // Setup phase then access phase, no wait states.
    task automatic apbAccess(logic [`APB_AW-1:0] addr, logic write, logic [31:0] data);
        for (int ph = 0; ph < 2; ph++) begin
            nextCycle();
            psel    = 1'b1;
            penable = (ph == 1);
            pwrite  = write;
            paddr   = addr;
            pwdata  = data;
        end
    endtask

    initial begin
        lfsr = 32'hf6b9_ad6e;
        rst = 1'b1;
        loadUop = '0;
        storeUop = '0;
        branchIn = '0;
        loadStall = 1'b0;
        storeStall = 1'b0;
        commitSqN = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        nextLq = '0;
        storeCnt = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Insert six loads, then retire three of them.
        for (int i = 0; i < 6; i++) begin
            nextCycle();
            driveLoad(SqN'(20 + 2 * i), 30'(i), 1'b0);
        end
        apbAccess(STATUS, 1'b0, 32'd0);
        for (int i = 0; i < 3; i++) begin
            nextCycle();
            commitSqN = SqN'(21 + 2 * i);
            apbAccess(STATUS, 1'b0, 32'd0);
        end

        // Loads left: sqN 26, 28, 30 on words 3, 4, 5.
        nextCycle();
        driveStore(SqN'(25), 30'd4, 1'b0);
        nextCycle();
        driveStore(SqN'(25), 30'd4, 1'b1);
        nextCycle();
        driveStore(SqN'(25), 30'd9, 1'b0); // No load on this word.
        nextCycle();
        driveStore(SqN'(31), 30'd4, 1'b0); // Matching load is older.
        for (int i = 0; i < 8; i++) begin
            nextCycle();
            driveStore(SqN'(24 + randBits(3)), 30'(randBits(3)), 1'(randBits(1)));
        end

        // Load and store in the same cycle, then the stalled case.
        nextCycle();
        driveLoad(SqN'(34), 30'd9, 1'b0);
        driveStore(SqN'(33), 30'd9, 1'b0);
        nextCycle();
        driveLoad(SqN'(36), 30'd10, 1'b1);
        driveStore(SqN'(35), 30'd10, 1'b0);
        nextCycle();
        driveLoad(SqN'(36), 30'd10, 1'b0);

        // Mispredict at sqN 29 drops the loads at 30, 34 and 36.
        nextCycle();
        driveBranch(SqN'(29), SqN'(0), 1'b0);
        nextCycle();
        driveStore(SqN'(25), 30'd5, 1'b0);
        nextCycle();
        driveStore(SqN'(25), 30'd4, 1'b0);
        nextCycle();
        commitSqN = SqN'(40);
        repeat (3) nextCycle();
        nextCycle();
        driveBranch(SqN'(40), SqN'(20), 1'b1);
        nextLq = SqN'(20);
        repeat (3) nextCycle();

        // Register block.
        nextCycle();
        driveLoad(SqN'(42), 30'd1, 1'b0);
        nextCycle();
        driveLoad(SqN'(44), 30'd2, 1'b0);
        apbAccess(CTRL, 1'b1, 32'd0);
        nextCycle();
        driveStore(SqN'(41), 30'd1, 1'b0); // Suppressed.
        apbAccess(STATUS, 1'b0, 32'd0);
        apbAccess(CTRL, 1'b1, 32'd1);
        apbAccess(CTRL, 1'b0, 32'd0);
        nextCycle();
        driveStore(SqN'(41), 30'd2, 1'b1);
        repeat (2) nextCycle();
        apbAccess(LASTPC, 1'b0, 32'd0);
        apbAccess(VIOLCNT, 1'b0, 32'd0);
        apbAccess(VIOLCNT, 1'b1, 32'h1234);
        apbAccess(VIOLCNT, 1'b0, 32'd0);
        apbAccess(4'h2, 1'b0, 32'd0);
        repeat (2) nextCycle();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
+incdir+verif
common/lsqPkg.sv
hw/loadBuffer/storeOrderCheck.sv
hw/loadBuffer/loadBuffer.sv
hw/lsqConfig.sv
hw/memOrderTop.sv
verif/memOrderTb.sv
